/* axi_pkg.sv */
`include "cbus_axi_settings.svh"

package axi_pkg;

    // AXI burst length field, beat count minus one
    typedef logic [`AXI_LEN_BITS-1:0] axi_len_t;

    // response code of the r and b channels
    // only OKAY (2'b00) is ever returned by the RAM slave,
    // so the code does not travel on a port
    typedef logic [1:0] axi_resp_code_t;

    // burst handling in the RAM slave
    //   IDLE         both address channels ready, read wins
    //   READ_BEATS   one r beat per cycle while r_ready
    //   WRITE_BEATS  one w beat per cycle while w_valid
    //   WRITE_RESP   b_valid held until b_ready
    typedef enum logic [1:0] {
        IDLE,
        READ_BEATS,
        WRITE_BEATS,
        WRITE_RESP
    } slave_state_t;

endpackage

/* axi_ram_slave.sv */
`timescale 1ns/1ps

`include "cbus_axi_settings.svh"

module axi_ram_slave (
    input  logic              clk,
    input  logic              reset,

    input  logic              ar_valid,
    input  cbus_pkg::addr_t   ar_addr,
    input  axi_pkg::axi_len_t ar_len,
    output logic              ar_ready,

    output logic              r_valid,
    output cbus_pkg::word_t   r_data,
    output logic              r_last,
    input  logic              r_ready,

    input  logic              aw_valid,
    input  cbus_pkg::addr_t   aw_addr,
    input  axi_pkg::axi_len_t aw_len,
    output logic              aw_ready,

    input  logic              w_valid,
    input  cbus_pkg::word_t   w_data,
    input  logic              w_last,
    output logic              w_ready,

    output logic              b_valid,
    input  logic              b_ready
);
    import cbus_pkg::*;
    import axi_pkg::*;

    localparam int RAM_AW = $clog2(`AXI_RAM_WORDS);

    typedef logic [RAM_AW-1:0] ram_idx_t;

    word_t        mem [`AXI_RAM_WORDS];
    slave_state_t state;
    ram_idx_t     word_idx;
    axi_len_t     beats_left;

    // word index from the byte address, upper bits wrap the RAM
    ram_idx_t ar_idx;
    ram_idx_t aw_idx;

    assign ar_idx = ar_addr[RAM_AW+1:2];
    assign aw_idx = aw_addr[RAM_AW+1:2];

    logic ar_hs;
    logic aw_hs;
    logic r_hs;
    logic w_hs;
    logic w_end;

    assign ar_ready = state == IDLE;
    assign aw_ready = state == IDLE;
    assign r_valid  = state == READ_BEATS;
    assign w_ready  = state == WRITE_BEATS;
    assign b_valid  = state == WRITE_RESP;
    assign r_last   = r_valid && (beats_left == '0);

    // read address wins when both arrive together
    assign ar_hs = ar_valid && ar_ready;
    assign aw_hs = aw_valid && aw_ready && !ar_hs;
    assign r_hs  = r_valid && r_ready;
    assign w_hs  = w_valid && w_ready;

    // burst closes on w_last, or once the announced beats are used up
    assign w_end = w_hs && (w_last || (beats_left == '0));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (ar_hs) begin
                        state <= READ_BEATS;
                    end else if (aw_hs) begin
                        state <= WRITE_BEATS;
                    end
                end
                READ_BEATS: begin
                    if (r_hs && r_last) begin
                        state <= IDLE;
                    end
                end
                WRITE_BEATS: begin
                    if (w_end) begin
                        state <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (b_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // burst position and read data register
    // the first read word is fetched on the address handshake itself
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r_data     <= mem[ar_idx];
            word_idx   <= ar_idx + ram_idx_t'(1);
            beats_left <= ar_len;
        end else if (aw_hs) begin
            word_idx   <= aw_idx;
            beats_left <= aw_len;
        end else if (r_hs && !r_last) begin
            r_data     <= mem[word_idx];
            word_idx   <= word_idx + ram_idx_t'(1);
            beats_left <= beats_left - axi_len_t'(1);
        end else if (w_hs) begin
            word_idx   <= word_idx + ram_idx_t'(1);
            beats_left <= beats_left - axi_len_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            mem[word_idx] <= w_data;
        end
    end

endmodule

/* cbus_axi_mem.f */
+incdir+.
cbus_pkg.sv
axi_pkg.sv
cbus_to_axi.sv
axi_ram_slave.sv
cbus_axi_mem.sv
cbus_axi_mem_assert.sv
cbus_axi_mem_tb.sv

/* cbus_axi_mem.sv */
`timescale 1ns/1ps

module cbus_axi_mem (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  cbus_valid,
    input  logic                  cbus_is_write,
    input  cbus_pkg::addr_t       cbus_addr,
    input  cbus_pkg::cbus_order_t cbus_order,
    input  cbus_pkg::word_t       cbus_wdata,
    output logic                  cbus_okay,
    output logic                  cbus_last,
    output cbus_pkg::word_t       cbus_rdata
);
    import cbus_pkg::*;
    import axi_pkg::*;

    // AXI between bridge and RAM
    logic     ar_valid;
    addr_t    ar_addr;
    axi_len_t ar_len;
    logic     ar_ready;
    logic     r_valid;
    word_t    r_data;
    logic     r_last;
    logic     r_ready;
    logic     aw_valid;
    addr_t    aw_addr;
    axi_len_t aw_len;
    logic     aw_ready;
    logic     w_valid;
    word_t    w_data;
    logic     w_last;
    logic     w_ready;
    logic     b_valid;
    logic     b_ready;

    cbus_to_axi u_bridge (
        .clk           (clk),
        .reset         (reset),
        .cbus_valid    (cbus_valid),
        .cbus_is_write (cbus_is_write),
        .cbus_addr     (cbus_addr),
        .cbus_order    (cbus_order),
        .cbus_wdata    (cbus_wdata),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata),
        .ar_valid      (ar_valid),
        .ar_addr       (ar_addr),
        .ar_len        (ar_len),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r_data        (r_data),
        .r_last        (r_last),
        .r_ready       (r_ready),
        .aw_valid      (aw_valid),
        .aw_addr       (aw_addr),
        .aw_len        (aw_len),
        .aw_ready      (aw_ready),
        .w_valid       (w_valid),
        .w_data        (w_data),
        .w_last        (w_last),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b_ready       (b_ready)
    );

    axi_ram_slave u_ram (
        .clk      (clk),
        .reset    (reset),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_last   (r_last),
        .r_ready  (r_ready),
        .aw_valid (aw_valid),
        .aw_addr  (aw_addr),
        .aw_len   (aw_len),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w_data   (w_data),
        .w_last   (w_last),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

/* cbus_axi_mem_assert.sv */
`timescale 1ns/1ps

module cbus_axi_mem_assert (
    input logic              clk,
    input logic              reset,
    input logic              cbus_is_write,
    input logic              cbus_okay,
    input logic              cbus_last,
    input logic              ar_valid,
    input logic              ar_ready,
    input cbus_pkg::addr_t   ar_addr,
    input axi_pkg::axi_len_t ar_len,
    input logic              aw_valid,
    input logic              aw_ready,
    input cbus_pkg::addr_t   aw_addr,
    input axi_pkg::axi_len_t aw_len,
    input logic              w_valid,
    input logic              w_ready,
    input cbus_pkg::word_t   w_data,
    input logic              w_last
);
    import axi_pkg::*;

    // beats left after the current one in the open write burst
    axi_len_t w_left;

    always_ff @(posedge clk) begin
        if (reset) begin
            w_left <= '0;
        end else if (aw_valid && aw_ready) begin
            w_left <= aw_len;
        end else if (w_valid && w_ready) begin
            w_left <= w_left - axi_len_t'(1);
        end
    end

    no_dual_address: assert property (@(posedge clk) disable iff (reset)
        !(ar_valid && aw_valid))
        else $error("ar_valid and aw_valid high in the same cycle");

    w_last_count: assert property (@(posedge clk) disable iff (reset)
        (w_valid && w_ready) |-> (w_last == (w_left == '0)))
        else $error("w_last does not match the burst length");

    read_last_okay: assert property (@(posedge clk) disable iff (reset)
        (cbus_last && !cbus_is_write) |-> cbus_okay)
        else $error("read cbus_last without cbus_okay");

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr) && $stable(ar_len)))
        else $error("read address changed before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw_addr) && $stable(aw_len)))
        else $error("write address changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (reset)
        (w_valid && !w_ready) |=> (w_valid && $stable(w_data) && $stable(w_last)))
        else $error("write data changed before w_ready");

endmodule

bind cbus_to_axi cbus_axi_mem_assert u_protocol_check (
    .clk           (clk),
    .reset         (reset),
    .cbus_is_write (cbus_is_write),
    .cbus_okay     (cbus_okay),
    .cbus_last     (cbus_last),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .ar_addr       (ar_addr),
    .ar_len        (ar_len),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .aw_addr       (aw_addr),
    .aw_len        (aw_len),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .w_data        (w_data),
    .w_last        (w_last)
);

/* cbus_axi_mem_input.txt */
# columns: op (0 read, 1 write), start byte address, order (log2 of words), data base
# all fields hex, the data base is ignored on reads
1 00000010 0 a5a50000
0 00000010 0 00000000
1 00000020 1 11110000
0 00000020 1 00000000
1 00000040 2 22220000
0 00000040 2 00000000
0 00000044 1 00000000
1 00000080 3 33330000
0 00000080 3 00000000
1 00000100 4 44440000
0 00000100 4 00000000
0 00000108 2 00000000
1 000003f8 2 55550000
0 00000000 1 00000000
0 000003f8 2 00000000
1 00000800 3 66660000
0 00000000 3 00000000
0 00000400 3 00000000
1 00000c40 4 77770000
0 00000040 4 00000000
0 00000010 0 00000000
1 000003c0 4 88880000
0 000003c0 4 00000000
1 000003e0 4 99990000
0 000003e0 4 00000000
0 000003f0 3 00000000
0 00000000 2 00000000
1 00000200 0 deadbeef
1 00000204 0 cafe0000
0 00000200 1 00000000
1 00000180 2 0f0f0000
1 00000190 2 f0f00000
0 00000180 3 00000000
0 00000184 2 00000000
1 00000300 1 12340000
0 00000300 1 00000000
0 0000013c 0 00000000
0 00000100 3 00000000

/* cbus_axi_mem_tb.sv */
`timescale 1ns/1ps

`include "cbus_axi_settings.svh"

module cbus_axi_mem_tb;
    import cbus_pkg::*;

    localparam int MAX_REQ    = 64;
    localparam int IDLE_CHECK = 8;

    logic        clk;
    logic        reset;
    logic        cbus_valid;
    logic        cbus_is_write;
    addr_t       cbus_addr;
    cbus_order_t cbus_order;
    word_t       cbus_wdata;
    logic        cbus_okay;
    logic        cbus_last;
    word_t       cbus_rdata;

    // requests from the input file
    logic        req_write [MAX_REQ];
    addr_t       req_addr  [MAX_REQ];
    cbus_order_t req_order [MAX_REQ];
    word_t       req_base  [MAX_REQ];
    int          num_req;

    // reference copy of the RAM, indexed by word
    word_t shadow  [`AXI_RAM_WORDS];
    logic  written [`AXI_RAM_WORDS];

    int cycle_cnt   = 0;
    int cycle_limit = 0;

    cbus_axi_mem i_dut (
        .clk           (clk),
        .reset         (reset),
        .cbus_valid    (cbus_valid),
        .cbus_is_write (cbus_is_write),
        .cbus_addr     (cbus_addr),
        .cbus_order    (cbus_order),
        .cbus_wdata    (cbus_wdata),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped after an error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
            fail_run("timeout, the requests did not finish within the cycle limit");
        end
    end

    // word i of a write request
    function automatic word_t write_word(input int r, input int i);
        return req_base[r] + word_t'(i) * 32'h0101_0101;
    endfunction

    // byte address to RAM word, wrapping at the RAM depth
    function automatic int word_index(input addr_t addr);
        return int'((addr >> 2) % `AXI_RAM_WORDS);
    endfunction

    task automatic load_requests();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_order;
        logic [31:0] f_base;
        fd = $fopen("cbus_axi_mem_input.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open cbus_axi_mem_input.txt");
        end
        num_req = 0;
        while (!$feof(fd) && (num_req < MAX_REQ)) begin
            cnt = $fgets(line, fd);
            if ((cnt > 0) && (line.len() > 1) && (line[0] != "#")) begin
                cnt = $sscanf(line, "%h %h %h %h", f_op, f_addr, f_order, f_base);
                if (cnt == 4) begin
                    req_write[num_req] = f_op != 0;
                    req_addr[num_req]  = f_addr;
                    req_order[num_req] = cbus_order_t'(f_order);
                    req_base[num_req]  = f_base;
                    num_req++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_request(input int r);
        int    n;
        int    idx;
        int    slot;
        logic  done;
        word_t exp_word;
        n    = 1 << req_order[r];
        idx  = 0;
        done = 1'b0;
        @(posedge clk);
        cbus_valid    <= 1'b1;
        cbus_is_write <= req_write[r];
        cbus_addr     <= req_addr[r];
        cbus_order    <= req_order[r];
        cbus_wdata    <= write_word(r, 0);
        while (!done) begin
            @(negedge clk);
            if (cbus_last) begin
                assert (cbus_okay) else fail_run("cbus_last seen without cbus_okay");
            end
            if (cbus_okay) begin
                assert (idx < n) else fail_run("more okay pulses than words in the request");
                slot = word_index(req_addr[r] + addr_t'(idx * 4));
                if (req_write[r]) begin
                    shadow[slot]  = write_word(r, idx);
                    written[slot] = 1'b1;
                end else begin
                    assert (written[slot]) else fail_run("read of a location never written");
                    exp_word = shadow[slot];
                    assert (cbus_rdata == exp_word) else
                        fail_run($sformatf("FAILED cbus_rdata exp %h got %h",
                                           exp_word, cbus_rdata));
                end
                idx++;
            end
            if (cbus_last) begin
                assert (idx == n) else
                    fail_run($sformatf("FAILED okay count exp %h got %h", n, idx));
                done = 1'b1;
            end else if (cbus_okay && req_write[r]) begin
                // master moves to the next word after each okay
                @(posedge clk);
                cbus_wdata <= write_word(r, idx);
            end
        end
    endtask

    initial begin
        reset         <= 1'b1;
        cbus_valid    <= 1'b0;
        cbus_is_write <= 1'b0;
        cbus_addr     <= '0;
        cbus_order    <= '0;
        cbus_wdata    <= '0;
        for (int i = 0; i < `AXI_RAM_WORDS; i++) begin
            written[i] = 1'b0;
        end
        load_requests();
        assert (num_req > 0) else fail_run("no requests found in the input file");
        // budget covers reset, both idle windows and every request
        cycle_limit = 16 + 2 * IDLE_CHECK + 4;
        for (int r = 0; r < num_req; r++) begin
            cycle_limit += (1 << req_order[r]) * 4 + 20;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // bus must stay quiet until the first request
        repeat (IDLE_CHECK) begin
            @(negedge clk);
            assert (!cbus_okay && !cbus_last) else
                fail_run("okay or last seen while no request was pending");
        end
        for (int r = 0; r < num_req; r++) begin
            run_request(r);
        end
        @(posedge clk);
        cbus_valid <= 1'b0;
        // nothing may follow the final last once valid is gone
        repeat (IDLE_CHECK) begin
            @(negedge clk);
            assert (!cbus_okay && !cbus_last) else
                fail_run("okay or last seen after the final request");
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* cbus_axi_settings.svh */
`ifndef CBUS_AXI_SETTINGS_SVH
`define CBUS_AXI_SETTINGS_SVH

// width of one data word, shared by the cache bus and both AXI data channels
`define CBUS_DATA_WIDTH 32

// width of the word count taken from the cache-bus order
// a request of order n moves 2^n words, so 4 bits cover up to 16 words
`define CBUS_LEN_BITS 4

// width of AXI len
// 2 bits limit a burst to 4 beats, so long requests are split into
// several bursts by the bridge
`define AXI_LEN_BITS 2

// number of 32-bit words in the RAM behind the AXI slave
// byte addresses beyond this wrap around
`define AXI_RAM_WORDS 256

`endif

/* cbus_pkg.sv */
`include "cbus_axi_settings.svh"

package cbus_pkg;

    // byte address as seen by the cache
    // the low two bits are always zero for word requests
    typedef logic [31:0] addr_t;

    // one data word on the cache bus
    typedef logic [`CBUS_DATA_WIDTH-1:0] word_t;

    // log2 of the number of words in one request
    // legal values run from 0 (single word) to 4 (16 words)
    typedef logic [2:0] cbus_order_t;

endpackage

/* cbus_to_axi.sv */
`timescale 1ns/1ps

`include "cbus_axi_settings.svh"

module cbus_to_axi (
    input  logic                 clk,
    input  logic                 reset,

    // cache bus
    input  logic                 cbus_valid,
    input  logic                 cbus_is_write,
    input  cbus_pkg::addr_t      cbus_addr,
    input  cbus_pkg::cbus_order_t cbus_order,
    input  cbus_pkg::word_t      cbus_wdata,
    output logic                 cbus_okay,
    output logic                 cbus_last,
    output cbus_pkg::word_t      cbus_rdata,

    // AXI master side
    output logic                 ar_valid,
    output cbus_pkg::addr_t      ar_addr,
    output axi_pkg::axi_len_t    ar_len,
    input  logic                 ar_ready,

    input  logic                 r_valid,
    input  cbus_pkg::word_t      r_data,
    input  logic                 r_last,
    output logic                 r_ready,

    output logic                 aw_valid,
    output cbus_pkg::addr_t      aw_addr,
    output axi_pkg::axi_len_t    aw_len,
    input  logic                 aw_ready,

    output logic                 w_valid,
    output cbus_pkg::word_t      w_data,
    output logic                 w_last,
    input  logic                 w_ready,

    input  logic                 b_valid,
    output logic                 b_ready
);
    import cbus_pkg::*;
    import axi_pkg::*;

    // bits of the word count that do not fit into AXI len
    // they count the bursts of a split request
    localparam int EXCEED_BITS = `CBUS_LEN_BITS - `AXI_LEN_BITS;
    localparam int COUNT_BITS  = `CBUS_LEN_BITS;

    typedef logic [EXCEED_BITS-1:0] round_t;
    typedef logic [COUNT_BITS-1:0]  count_t;

    typedef enum logic [1:0] {
        IDLE,
        TRANSFER,
        REQUEST,
        WAITING
    } bridge_state_t;

    bridge_state_t state;
    addr_t         current_addr;
    round_t        round_cnt;
    axi_len_t      len_cnt;

    // word count minus one, split into bursts minus one and beats minus one
    // order 4 wraps to zero before the subtraction and gives all ones
    count_t   words_m1;
    round_t   num_round;
    axi_len_t axi_len;
    addr_t    addr_step;

    assign words_m1              = (count_t'(1) << cbus_order) - count_t'(1);
    assign {num_round, axi_len}  = words_m1;

    // next burst starts one full burst of words higher
    assign addr_step = (addr_t'(axi_len) + addr_t'(1)) << 2;

    logic addr_ok;
    logic rw_handshake;
    logic transaction_ok;
    logic is_last;
    logic is_final;
    logic issue;

    assign addr_ok        = cbus_is_write ? aw_ready : ar_ready;
    assign rw_handshake   = (w_valid && w_ready) || (r_valid && r_ready);
    assign transaction_ok = b_valid && b_ready;

    assign is_last  = len_cnt == '0;
    assign is_final = is_last && (round_cnt == '0);

    // address channel, new request in IDLE or follow-up burst in REQUEST
    assign issue    = ((state == IDLE) && cbus_valid) || (state == REQUEST);
    assign ar_valid = issue && !cbus_is_write;
    assign aw_valid = issue && cbus_is_write;
    assign ar_addr  = (state == IDLE) ? cbus_addr : current_addr;
    assign aw_addr  = ar_addr;
    assign ar_len   = axi_len;
    assign aw_len   = axi_len;

    // data channels follow the cache bus directly
    assign w_valid = (state == TRANSFER) && cbus_is_write;
    assign w_data  = cbus_wdata;
    assign w_last  = w_valid && is_last;
    assign r_ready = (state == TRANSFER) && !cbus_is_write;
    assign b_ready = state == WAITING;

    assign cbus_rdata = r_data;

    // the last write word of each burst is acknowledged by its b handshake,
    // so the cache does not move on before the burst is committed
    assign cbus_okay = (cbus_is_write && is_last) ? transaction_ok : rw_handshake;
    assign cbus_last = is_final && (cbus_is_write ? transaction_ok : (rw_handshake && r_last));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            round_cnt <= '0;
            len_cnt   <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (cbus_valid && addr_ok) begin
                        state     <= TRANSFER;
                        round_cnt <= num_round;
                        len_cnt   <= axi_len;
                    end
                end
                TRANSFER: begin
                    if (rw_handshake) begin
                        if (!is_last) begin
                            len_cnt <= len_cnt - axi_len_t'(1);
                        end else if (cbus_is_write) begin
                            state <= WAITING;
                        end else if (is_final) begin
                            state <= IDLE;
                        end else begin
                            state <= REQUEST;
                        end
                    end
                end
                REQUEST: begin
                    if (addr_ok) begin
                        state     <= TRANSFER;
                        round_cnt <= round_cnt - round_t'(1);
                        len_cnt   <= axi_len;
                    end
                end
                WAITING: begin
                    if (transaction_ok) begin
                        state <= is_final ? IDLE : REQUEST;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // start address of the next burst
    always_ff @(posedge clk) begin
        if ((state == IDLE) && cbus_valid && addr_ok) begin
            current_addr <= cbus_addr + addr_step;
        end else if ((state == REQUEST) && addr_ok) begin
            current_addr <= current_addr + addr_step;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cbus_axi_mem_tb -f cbus_axi_mem.f -o cbus_axi_mem_sim &&
./obj_dir/cbus_axi_mem_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }
